// ==== include/cpuCtrl_params.svh ====
`ifndef CPU_CTRL_PARAMS_SVH
`define CPU_CTRL_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Instruction field layout
////////////////////////////////////////////////////////////////////////////

`define CTRL_IR_WIDTH 6
`define CTRL_OPCODE_WIDTH 4      // Upper bits of ir
`define CTRL_MODE_WIDTH 2        // Lower bits, zero is immediate

////////////////////////////////////////////////////////////////////////////
// Datapath select widths and sequence lengths
////////////////////////////////////////////////////////////////////////////

`define CTRL_WRITE_SRC_WIDTH 3

// Words pushed by call, popped by return
`define CTRL_CALL_WORDS 4

// One-hot state vector width
`define CTRL_STATE_COUNT 39

`endif

// ==== rtl/cpuCtrlPkg.sv ====
`default_nettype none

`include "cpuCtrl_params.svh"

package cpuCtrlPkg;

    typedef logic [`CTRL_STATE_COUNT-1:0] stateBits_t;

    // One bit per state, MSB first
    typedef enum stateBits_t {
        stReset     = stateBits_t'(1) << 38,
        stCheck     = stateBits_t'(1) << 37,     // Instruction boundary
        stFetch0    = stateBits_t'(1) << 36,
        stFetch1    = stateBits_t'(1) << 35,
        stFetch2    = stateBits_t'(1) << 34,
        stCall0     = stateBits_t'(1) << 33,
        stCall1     = stateBits_t'(1) << 32,
        stCall2     = stateBits_t'(1) << 31,
        stCall3     = stateBits_t'(1) << 30,
        stCall4     = stateBits_t'(1) << 29,
        stCall5     = stateBits_t'(1) << 28,
        stCall6     = stateBits_t'(1) << 27,
        stCall7     = stateBits_t'(1) << 26,
        stCall8     = stateBits_t'(1) << 25,
        stAlu0      = stateBits_t'(1) << 24,
        stAluImm    = stateBits_t'(1) << 23,
        stAlu1      = stateBits_t'(1) << 22,
        stAlu2      = stateBits_t'(1) << 21,
        stLoad0     = stateBits_t'(1) << 20,
        stLoadImm   = stateBits_t'(1) << 19,
        stLoad1     = stateBits_t'(1) << 18,
        stLoad2     = stateBits_t'(1) << 17,
        stStore0    = stateBits_t'(1) << 16,
        stBranch0   = stateBits_t'(1) << 15,
        stBranchImm = stateBits_t'(1) << 14,
        stBranch1   = stateBits_t'(1) << 13,
        stBranch2   = stateBits_t'(1) << 12,
        stJump0     = stateBits_t'(1) << 11,
        stJumpImm   = stateBits_t'(1) << 10,
        stJump1     = stateBits_t'(1) << 9,
        stJump2     = stateBits_t'(1) << 8,
        stRet0      = stateBits_t'(1) << 7,
        stRet1      = stateBits_t'(1) << 6,
        stRet2      = stateBits_t'(1) << 5,
        stRet3      = stateBits_t'(1) << 4,
        stRet4      = stateBits_t'(1) << 3,
        stRet5      = stateBits_t'(1) << 2,
        stRet6      = stateBits_t'(1) << 1,
        stRet7      = stateBits_t'(1)
    } ctrlState_t;

    typedef enum logic [`CTRL_OPCODE_WIDTH-1:0] {
        opAdd, opSub, opAnd, opOr, opXor, opShl, opShr,   // ALU group
        opBranch    = 4'd7,
        opJump      = 4'd8,
        opReturn    = 4'd9,
        opLoad      = 4'd10,
        opStore     = 4'd11,
        opReserved0 = 4'd12,
        opReserved1 = 4'd13,
        opReserved2 = 4'd14,
        opCall      = 4'd15
    } opcode_t;

    typedef enum logic [1:0] {pcHold, pcLoad, pcIncrement, pcClear} pcCtrl_t;
    typedef enum logic [1:0] {spHold, spClear, spPush, spPop} spCtrl_t;

    typedef enum logic [1:0] {
        accMemory    = 2'd1,
        accAlu       = 2'd2,
        accImmediate = 2'd3
    } accSrc_t;

    typedef enum logic [1:0] {
        pcFromMemory  = 2'd0,
        pcFromOperand = 2'd2
    } pcSrc_t;

    // Source of the word written to data memory
    typedef enum logic [`CTRL_WRITE_SRC_WIDTH-1:0] {
        writeAcc     = 3'd0,
        writeFlags   = 3'd1,
        writePc      = 3'd3,
        writeOperand = 3'd4
    } writeSrc_t;

endpackage

`default_nettype wire

// ==== rtl/stateSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuCtrl_params.svh"

module stateSequencer (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic [`CTRL_IR_WIDTH-1:0] ir,
    input  wire logic                      zero,
    input  wire logic                      instAck,
    input  wire logic                      dataAck,
    output cpuCtrlPkg::ctrlState_t         state
);

    cpuCtrlPkg::ctrlState_t nextState;
    cpuCtrlPkg::opcode_t    opcode;
    logic                   immediate;

    assign opcode = cpuCtrlPkg::opcode_t'(ir[`CTRL_IR_WIDTH-1 -: `CTRL_OPCODE_WIDTH]);
    assign immediate = (ir[`CTRL_MODE_WIDTH-1:0] == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpuCtrlPkg::stReset;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = cpuCtrlPkg::stReset;    // Illegal encodings recover here
        case (state)
            cpuCtrlPkg::stReset: nextState = cpuCtrlPkg::stCheck;
            cpuCtrlPkg::stCheck: nextState = cpuCtrlPkg::stFetch0;

            ////////////////////////////////////////////////////////////////////////
            // Fetch and decode
            ////////////////////////////////////////////////////////////////////////
            cpuCtrlPkg::stFetch0:
                nextState = instAck ? cpuCtrlPkg::stFetch1 : cpuCtrlPkg::stFetch0;
            cpuCtrlPkg::stFetch1: nextState = cpuCtrlPkg::stFetch2;
            cpuCtrlPkg::stFetch2: begin
                case (opcode)
                    cpuCtrlPkg::opAdd, cpuCtrlPkg::opSub, cpuCtrlPkg::opAnd,
                    cpuCtrlPkg::opOr, cpuCtrlPkg::opXor, cpuCtrlPkg::opShl,
                    cpuCtrlPkg::opShr:     nextState = cpuCtrlPkg::stAlu0;
                    cpuCtrlPkg::opBranch:  nextState = cpuCtrlPkg::stBranch0;
                    cpuCtrlPkg::opJump:    nextState = cpuCtrlPkg::stJump0;
                    cpuCtrlPkg::opReturn:  nextState = cpuCtrlPkg::stRet0;
                    cpuCtrlPkg::opLoad:    nextState = cpuCtrlPkg::stLoad0;
                    cpuCtrlPkg::opStore:   nextState = cpuCtrlPkg::stStore0;
                    cpuCtrlPkg::opCall:    nextState = cpuCtrlPkg::stCall0;
                    default:               nextState = cpuCtrlPkg::stCheck;  // No-op
                endcase
            end

            // Four pushes, then jump to the operand
            cpuCtrlPkg::stCall0: nextState = cpuCtrlPkg::stCall1;
            cpuCtrlPkg::stCall1:
                nextState = dataAck ? cpuCtrlPkg::stCall2 : cpuCtrlPkg::stCall1;
            cpuCtrlPkg::stCall2: nextState = cpuCtrlPkg::stCall3;
            cpuCtrlPkg::stCall3:
                nextState = dataAck ? cpuCtrlPkg::stCall4 : cpuCtrlPkg::stCall3;
            cpuCtrlPkg::stCall4: nextState = cpuCtrlPkg::stCall5;
            cpuCtrlPkg::stCall5:
                nextState = dataAck ? cpuCtrlPkg::stCall6 : cpuCtrlPkg::stCall5;
            cpuCtrlPkg::stCall6: nextState = cpuCtrlPkg::stCall7;
            cpuCtrlPkg::stCall7:
                nextState = dataAck ? cpuCtrlPkg::stCall8 : cpuCtrlPkg::stCall7;
            cpuCtrlPkg::stCall8: nextState = cpuCtrlPkg::stCheck;

            ////////////////////////////////////////////////////////////////////////
            // Operand instructions
            ////////////////////////////////////////////////////////////////////////
            cpuCtrlPkg::stAlu0:
                nextState = immediate ? cpuCtrlPkg::stAluImm : cpuCtrlPkg::stAlu1;
            cpuCtrlPkg::stAluImm: nextState = cpuCtrlPkg::stCheck;
            cpuCtrlPkg::stAlu1:
                nextState = dataAck ? cpuCtrlPkg::stAlu2 : cpuCtrlPkg::stAlu1;
            cpuCtrlPkg::stAlu2: nextState = cpuCtrlPkg::stCheck;

            cpuCtrlPkg::stLoad0:
                nextState = immediate ? cpuCtrlPkg::stLoadImm : cpuCtrlPkg::stLoad1;
            cpuCtrlPkg::stLoadImm: nextState = cpuCtrlPkg::stCheck;
            cpuCtrlPkg::stLoad1:
                nextState = dataAck ? cpuCtrlPkg::stLoad2 : cpuCtrlPkg::stLoad1;
            cpuCtrlPkg::stLoad2: nextState = cpuCtrlPkg::stCheck;

            cpuCtrlPkg::stStore0:
                nextState = dataAck ? cpuCtrlPkg::stCheck : cpuCtrlPkg::stStore0;

            cpuCtrlPkg::stBranch0: begin
                if (!zero) begin
                    nextState = cpuCtrlPkg::stCheck;    // Not taken
                end else if (immediate) begin
                    nextState = cpuCtrlPkg::stBranchImm;
                end else begin
                    nextState = cpuCtrlPkg::stBranch1;
                end
            end
            cpuCtrlPkg::stBranchImm: nextState = cpuCtrlPkg::stCheck;
            cpuCtrlPkg::stBranch1:
                nextState = dataAck ? cpuCtrlPkg::stBranch2 : cpuCtrlPkg::stBranch1;
            cpuCtrlPkg::stBranch2: nextState = cpuCtrlPkg::stCheck;

            cpuCtrlPkg::stJump0:
                nextState = immediate ? cpuCtrlPkg::stJumpImm : cpuCtrlPkg::stJump1;
            cpuCtrlPkg::stJumpImm: nextState = cpuCtrlPkg::stCheck;
            cpuCtrlPkg::stJump1:
                nextState = dataAck ? cpuCtrlPkg::stJump2 : cpuCtrlPkg::stJump1;
            cpuCtrlPkg::stJump2: nextState = cpuCtrlPkg::stCheck;

            // Four pops, read then pop
            cpuCtrlPkg::stRet0:
                nextState = dataAck ? cpuCtrlPkg::stRet1 : cpuCtrlPkg::stRet0;
            cpuCtrlPkg::stRet1: nextState = cpuCtrlPkg::stRet2;
            cpuCtrlPkg::stRet2:
                nextState = dataAck ? cpuCtrlPkg::stRet3 : cpuCtrlPkg::stRet2;
            cpuCtrlPkg::stRet3: nextState = cpuCtrlPkg::stRet4;
            cpuCtrlPkg::stRet4:
                nextState = dataAck ? cpuCtrlPkg::stRet5 : cpuCtrlPkg::stRet4;
            cpuCtrlPkg::stRet5: nextState = cpuCtrlPkg::stRet6;
            cpuCtrlPkg::stRet6:
                nextState = dataAck ? cpuCtrlPkg::stRet7 : cpuCtrlPkg::stRet6;
            cpuCtrlPkg::stRet7: nextState = cpuCtrlPkg::stCheck;
            default: nextState = cpuCtrlPkg::stReset;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/datapathControl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuCtrl_params.svh"

module datapathControl (
    input  wire cpuCtrlPkg::ctrlState_t    state,
    input  wire logic [`CTRL_IR_WIDTH-1:0] ir,
    output logic                           clearRegs,
    output logic                           accLoad,
    output cpuCtrlPkg::accSrc_t            accSrc,
    output cpuCtrlPkg::pcCtrl_t            pcCtrl,
    output cpuCtrlPkg::pcSrc_t             pcSrc,
    output cpuCtrlPkg::spCtrl_t            spCtrl,
    output logic                           irLoad,
    output logic                           irSrc,
    output logic                           marLoad,
    output logic                           marSrc,
    output logic                           ccLoad,
    output logic                           ccSrc,
    output cpuCtrlPkg::writeSrc_t          writeSrc,
    output logic                           indirect,
    output logic                           aluSrc
);

    always_comb begin
        clearRegs = 1'b0;
        accLoad   = 1'b0;
        accSrc    = cpuCtrlPkg::accMemory;
        pcCtrl    = cpuCtrlPkg::pcHold;
        pcSrc     = cpuCtrlPkg::pcFromMemory;
        spCtrl    = cpuCtrlPkg::spHold;
        irLoad    = 1'b0;
        irSrc     = 1'b0;
        marLoad   = 1'b0;
        marSrc    = 1'b0;
        ccLoad    = 1'b0;
        ccSrc     = 1'b0;
        writeSrc  = cpuCtrlPkg::writeAcc;
        indirect  = 1'b0;
        aluSrc    = 1'b0;

        case (state)
            cpuCtrlPkg::stReset: begin
                clearRegs = 1'b1;
                pcCtrl    = cpuCtrlPkg::pcClear;
                spCtrl    = cpuCtrlPkg::spClear;
            end
            cpuCtrlPkg::stFetch2: begin
                pcCtrl  = cpuCtrlPkg::pcIncrement;
                irLoad  = 1'b1;
                irSrc   = 1'b1;     // Instruction bus into ir
                marLoad = 1'b1;     // Operand field into mar
            end

            ////////////////////////////////////////////////////////////////////////
            // Call pushes acc, pc, flags and operand
            ////////////////////////////////////////////////////////////////////////
            cpuCtrlPkg::stCall0, cpuCtrlPkg::stCall2,
            cpuCtrlPkg::stCall4, cpuCtrlPkg::stCall6:
                spCtrl = cpuCtrlPkg::spPush;
            cpuCtrlPkg::stCall3: writeSrc = cpuCtrlPkg::writePc;
            cpuCtrlPkg::stCall5: writeSrc = cpuCtrlPkg::writeFlags;
            cpuCtrlPkg::stCall7: writeSrc = cpuCtrlPkg::writeOperand;
            cpuCtrlPkg::stCall8: begin
                pcCtrl = cpuCtrlPkg::pcLoad;
                pcSrc  = cpuCtrlPkg::pcFromOperand;
            end

            cpuCtrlPkg::stAluImm: begin
                accLoad = 1'b1;
                accSrc  = cpuCtrlPkg::accAlu;
                ccLoad  = 1'b1;
                ccSrc   = 1'b1;
            end
            cpuCtrlPkg::stAlu2: begin
                accLoad = 1'b1;
                accSrc  = cpuCtrlPkg::accAlu;
                ccLoad  = 1'b1;
                ccSrc   = 1'b1;
                aluSrc  = 1'b1;     // Memory operand into the ALU
            end
            cpuCtrlPkg::stLoadImm: begin
                accLoad = 1'b1;
                accSrc  = cpuCtrlPkg::accImmediate;
            end
            cpuCtrlPkg::stLoad2: begin
                accLoad = 1'b1;
                accSrc  = cpuCtrlPkg::accMemory;
            end

            // Operand address direct or through memory
            cpuCtrlPkg::stAlu1, cpuCtrlPkg::stLoad1, cpuCtrlPkg::stStore0,
            cpuCtrlPkg::stBranch1, cpuCtrlPkg::stJump1:
                indirect = ir[0];

            cpuCtrlPkg::stBranchImm, cpuCtrlPkg::stJumpImm: begin
                pcCtrl = cpuCtrlPkg::pcLoad;
                pcSrc  = cpuCtrlPkg::pcFromOperand;
            end
            cpuCtrlPkg::stBranch2, cpuCtrlPkg::stJump2:
                pcCtrl = cpuCtrlPkg::pcLoad;

            ////////////////////////////////////////////////////////////////////////
            // Return pops in reverse push order
            ////////////////////////////////////////////////////////////////////////
            cpuCtrlPkg::stRet1: begin
                spCtrl  = cpuCtrlPkg::spPop;
                marLoad = 1'b1;
                marSrc  = 1'b1;
            end
            cpuCtrlPkg::stRet3: begin
                spCtrl = cpuCtrlPkg::spPop;
                irLoad = 1'b1;
                ccLoad = 1'b1;
            end
            cpuCtrlPkg::stRet5: begin
                spCtrl = cpuCtrlPkg::spPop;
                pcCtrl = cpuCtrlPkg::pcLoad;
            end
            cpuCtrlPkg::stRet7: begin
                spCtrl  = cpuCtrlPkg::spPop;
                accLoad = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/busControl.sv ====
`timescale 1ns/100ps
`default_nettype none

module busControl (
    input  wire cpuCtrlPkg::ctrlState_t state,
    output logic                        instCyc,
    output logic                        instStb,
    output logic                        dataCyc,
    output logic                        dataStb,
    output logic                        dataWe,
    output logic                        addrSrc
);

    ////////////////////////////////////////////////////////////////////////////
    // State groups as masks over the one-hot vector
    ////////////////////////////////////////////////////////////////////////////

    localparam cpuCtrlPkg::stateBits_t InstReadMask = cpuCtrlPkg::stFetch0;

    localparam cpuCtrlPkg::stateBits_t DataReadMask =
        cpuCtrlPkg::stAlu1 | cpuCtrlPkg::stLoad1 | cpuCtrlPkg::stBranch1 |
        cpuCtrlPkg::stJump1 | cpuCtrlPkg::stRet0 | cpuCtrlPkg::stRet2 |
        cpuCtrlPkg::stRet4 | cpuCtrlPkg::stRet6;

    localparam cpuCtrlPkg::stateBits_t DataWriteMask =
        cpuCtrlPkg::stStore0 | cpuCtrlPkg::stCall1 | cpuCtrlPkg::stCall3 |
        cpuCtrlPkg::stCall5 | cpuCtrlPkg::stCall7;

    // Stack pointer drives the data address
    localparam cpuCtrlPkg::stateBits_t StackMask =
        cpuCtrlPkg::stCall1 | cpuCtrlPkg::stCall3 | cpuCtrlPkg::stCall5 |
        cpuCtrlPkg::stCall7 | cpuCtrlPkg::stRet0 | cpuCtrlPkg::stRet2 |
        cpuCtrlPkg::stRet4 | cpuCtrlPkg::stRet6;

    logic instRead;
    logic dataRead;
    logic dataWrite;

    assign instRead  = |(state & InstReadMask);
    assign dataRead  = |(state & DataReadMask);
    assign dataWrite = |(state & DataWriteMask);

    // Held until ack as the state only moves on the ack edge
    assign instCyc = instRead;
    assign instStb = instRead;
    assign dataCyc = dataRead | dataWrite;
    assign dataStb = dataRead | dataWrite;
    assign dataWe  = dataWrite;
    assign addrSrc = |(state & StackMask);

endmodule

`default_nettype wire

// ==== rtl/cpuController.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuCtrl_params.svh"

module cpuController (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic [`CTRL_IR_WIDTH-1:0] ir,
    input  wire logic                      zero,
    input  wire logic                      instAck,
    input  wire logic                      dataAck,
    output logic                           clearRegs,
    output logic                           accLoad,
    output cpuCtrlPkg::accSrc_t            accSrc,
    output cpuCtrlPkg::pcCtrl_t            pcCtrl,
    output cpuCtrlPkg::pcSrc_t             pcSrc,
    output cpuCtrlPkg::spCtrl_t            spCtrl,
    output logic                           irLoad,
    output logic                           irSrc,
    output logic                           marLoad,
    output logic                           marSrc,
    output logic                           ccLoad,
    output logic                           ccSrc,
    output cpuCtrlPkg::writeSrc_t          writeSrc,
    output logic                           indirect,
    output logic                           aluSrc,
    output logic                           instCyc,
    output logic                           instStb,
    output logic                           dataCyc,
    output logic                           dataStb,
    output logic                           dataWe,
    output logic                           addrSrc
);

    cpuCtrlPkg::ctrlState_t state;

    stateSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .ir(ir),
        .zero(zero),
        .instAck(instAck),
        .dataAck(dataAck),
        .state(state)
    );

    datapathControl datapath (
        .state(state),
        .ir(ir),
        .clearRegs(clearRegs),
        .accLoad(accLoad),
        .accSrc(accSrc),
        .pcCtrl(pcCtrl),
        .pcSrc(pcSrc),
        .spCtrl(spCtrl),
        .irLoad(irLoad),
        .irSrc(irSrc),
        .marLoad(marLoad),
        .marSrc(marSrc),
        .ccLoad(ccLoad),
        .ccSrc(ccSrc),
        .writeSrc(writeSrc),
        .indirect(indirect),
        .aluSrc(aluSrc)
    );

    // Wishbone masters for both memories
    busControl bus (
        .state(state),
        .instCyc(instCyc),
        .instStb(instStb),
        .dataCyc(dataCyc),
        .dataStb(dataStb),
        .dataWe(dataWe),
        .addrSrc(addrSrc)
    );

endmodule

`default_nettype wire

// ==== bench/cpuControllerTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpuCtrl_params.svh"

module cpuControllerTb;

    logic                      clk = 1'b0;
    logic                      reset = 1'b1;
    logic [`CTRL_IR_WIDTH-1:0] ir = '0;
    logic                      zero = 1'b0;
    logic                      instAck = 1'b0;
    logic                      dataAck = 1'b0;

    logic clearRegs, accLoad, irLoad, irSrc, marLoad, marSrc, ccLoad, ccSrc;
    logic indirect, aluSrc, instCyc, instStb, dataCyc, dataStb, dataWe, addrSrc;
    cpuCtrlPkg::accSrc_t   accSrc;
    cpuCtrlPkg::pcCtrl_t   pcCtrl;
    cpuCtrlPkg::pcSrc_t    pcSrc;
    cpuCtrlPkg::spCtrl_t   spCtrl;
    cpuCtrlPkg::writeSrc_t writeSrc;

    cpuController DUT (
        .clk(clk), .reset(reset), .ir(ir), .zero(zero),
        .instAck(instAck), .dataAck(dataAck),
        .clearRegs(clearRegs), .accLoad(accLoad), .accSrc(accSrc),
        .pcCtrl(pcCtrl), .pcSrc(pcSrc), .spCtrl(spCtrl),
        .irLoad(irLoad), .irSrc(irSrc), .marLoad(marLoad), .marSrc(marSrc),
        .ccLoad(ccLoad), .ccSrc(ccSrc), .writeSrc(writeSrc),
        .indirect(indirect), .aluSrc(aluSrc),
        .instCyc(instCyc), .instStb(instStb), .dataCyc(dataCyc),
        .dataStb(dataStb), .dataWe(dataWe), .addrSrc(addrSrc)
    );

    localparam int TestCount = 6;

    logic [31:0] lfsr = 32'hcd98184f;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int delaySum = 0;

    // Per-instruction record
    int  reads, writes, pushes, pops, accLoads, pcLoads, incs, readsAtPcLoad;
    int  waitCnt, delay;
    logic pushPending, readPending, stackOp, writeOp;
    cpuCtrlPkg::accSrc_t lastAccSrc;
    cpuCtrlPkg::pcSrc_t  lastPcSrc;
    logic lastAluSrc, lastCcLoad;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > 60 * TestCount + delaySum) begin
            $display("Timeout: the controller did not finish the tests in time");
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random delays and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    function automatic int pickDelay();
        int value;
        value = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            value = (value << 1) | int'(lfsr[0]);
        end
        delaySum = delaySum + value;
        return value;
    endfunction

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic checkCount_(input string name, input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("[ERROR] %0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkAccSrc(input cpuCtrlPkg::accSrc_t got, input cpuCtrlPkg::accSrc_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t accSrc got %s exp %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic checkPcCtrl(input cpuCtrlPkg::pcCtrl_t got, input cpuCtrlPkg::pcCtrl_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t pcCtrl got %s exp %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic checkSpCtrl(input cpuCtrlPkg::spCtrl_t got, input cpuCtrlPkg::spCtrl_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t spCtrl got %s exp %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic checkPcSrc(input cpuCtrlPkg::pcSrc_t got, input cpuCtrlPkg::pcSrc_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t pcSrc got %s exp %s", $time, got.name(), exp.name());
        end
    endtask

    task automatic checkWriteSrc(input cpuCtrlPkg::writeSrc_t got,
                                 input cpuCtrlPkg::writeSrc_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t writeSrc got %s exp %s", $time, got.name(), exp.name());
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One instruction from fetch to the next fetch request
    ////////////////////////////////////////////////////////////////////////////

    task automatic observeCycle(inout logic fetched);
        checkBit("dataWe", dataWe, dataStb && writeOp);
        checkBit("addrSrc", addrSrc, dataStb && stackOp);
        checkBit("indirect", indirect, (dataStb && !stackOp) ? ir[0] : 1'b0);
        if (instStb) begin
            checkBit("instCyc", instCyc, 1'b1);
            checkBit("dataStb", dataStb, 1'b0);
            checkPcCtrl(pcCtrl, cpuCtrlPkg::pcHold);
            if (waitCnt == delay) begin
                instAck = 1'b1;
                fetched = 1'b1;
                waitCnt = 0;
                delay = pickDelay();
            end else begin
                waitCnt++;
            end
        end
        if (dataStb) begin
            checkBit("dataCyc", dataCyc, 1'b1);
            checkBit("accLoad", accLoad, 1'b0);
            checkPcCtrl(pcCtrl, cpuCtrlPkg::pcHold);
            if (writeOp && !stackOp) begin
                checkWriteSrc(writeSrc, cpuCtrlPkg::writeAcc);
                checkSpCtrl(spCtrl, cpuCtrlPkg::spHold);
            end
            if (waitCnt == delay) begin
                dataAck = 1'b1;
                waitCnt = 0;
                delay = pickDelay();
                if (dataWe) begin
                    writes++;
                    if (stackOp && !pushPending) begin
                        errorCount++;
                        $display("Stack write at %0t without a push before it", $time);
                    end
                    pushPending = 1'b0;
                end else begin
                    reads++;
                    readPending = 1'b1;
                end
            end else begin
                waitCnt++;
            end
        end
        if (spCtrl == cpuCtrlPkg::spPush) begin
            pushes++;
            pushPending = 1'b1;
        end
        if (spCtrl == cpuCtrlPkg::spPop) begin
            pops++;
            if (!readPending) begin
                errorCount++;
                $display("Stack pop at %0t without a read before it", $time);
            end
            readPending = 1'b0;
        end
        if (accLoad) begin
            accLoads++;
            lastAccSrc = accSrc;
            lastAluSrc = aluSrc;
            lastCcLoad = ccLoad;
        end
        if (pcCtrl == cpuCtrlPkg::pcLoad) begin
            pcLoads++;
            lastPcSrc = pcSrc;
            readsAtPcLoad = reads;
        end
        if (pcCtrl == cpuCtrlPkg::pcIncrement) begin
            incs++;
            checkBit("irLoad", irLoad, 1'b1);
        end
    endtask

    task automatic runInstruction(input cpuCtrlPkg::opcode_t op,
                                  input logic [`CTRL_MODE_WIDTH-1:0] mode, input logic z);
        logic fetched;
        logic done;
        fetched = 1'b0;
        done = 1'b0;
        {reads, writes, pushes, pops, accLoads, pcLoads, incs, readsAtPcLoad} = '0;
        pushPending = 1'b0;
        readPending = 1'b0;
        waitCnt = 0;
        delay = pickDelay();
        ir = {op, mode};
        zero = z;
        stackOp = (op == cpuCtrlPkg::opCall) || (op == cpuCtrlPkg::opReturn);
        writeOp = (op == cpuCtrlPkg::opCall) || (op == cpuCtrlPkg::opStore);
        while (!done) begin
            @(negedge clk);
            instAck = 1'b0;
            dataAck = 1'b0;
            if (instStb && fetched) begin
                done = 1'b1;                 // Next fetch has started
            end else begin
                observeCycle(fetched);
            end
        end
        checkCount_("pcIncrement count", incs, 1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic testResetFetch();
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            checkBit("clearRegs", clearRegs, 1'b1);
            checkPcCtrl(pcCtrl, cpuCtrlPkg::pcClear);
            checkSpCtrl(spCtrl, cpuCtrlPkg::spClear);
            checkBit("instCyc", instCyc, 1'b0);
            checkBit("instStb", instStb, 1'b0);
            checkBit("dataCyc", dataCyc, 1'b0);
            checkBit("dataStb", dataStb, 1'b0);
            checkBit("dataWe", dataWe, 1'b0);
            checkBit("accLoad", accLoad, 1'b0);
            checkBit("irLoad", irLoad, 1'b0);
            checkBit("marLoad", marLoad, 1'b0);
            checkBit("ccLoad", ccLoad, 1'b0);
            checkBit("irSrc", irSrc, 1'b0);
            checkBit("marSrc", marSrc, 1'b0);
            checkBit("ccSrc", ccSrc, 1'b0);
        end
        reset = 1'b0;
        runInstruction(cpuCtrlPkg::opReserved0, 2'd0, 1'b0);
        checkCount_("reserved accLoads", accLoads, 0);
        checkCount_("reserved pcLoads", pcLoads, 0);
    endtask

    task automatic testImmediate();
        runInstruction(cpuCtrlPkg::opXor, 2'd0, 1'b0);
        checkCount_("alu imm reads", reads, 0);
        checkCount_("alu imm accLoads", accLoads, 1);
        checkAccSrc(lastAccSrc, cpuCtrlPkg::accAlu);
        checkBit("ccLoad", lastCcLoad, 1'b1);
        runInstruction(cpuCtrlPkg::opLoad, 2'd0, 1'b0);
        checkCount_("load imm reads", reads, 0);
        checkCount_("load imm accLoads", accLoads, 1);
        checkAccSrc(lastAccSrc, cpuCtrlPkg::accImmediate);
    endtask

    task automatic testMemoryOperand();
        for (int mode = 1; mode < 4; mode++) begin
            runInstruction(cpuCtrlPkg::opAdd, mode[1:0], 1'b0);
            checkCount_("alu mem reads", reads, 1);
            checkCount_("alu mem accLoads", accLoads, 1);
            checkAccSrc(lastAccSrc, cpuCtrlPkg::accAlu);
            checkBit("aluSrc", lastAluSrc, 1'b1);
            runInstruction(cpuCtrlPkg::opLoad, mode[1:0], 1'b0);
            checkCount_("load mem reads", reads, 1);
            checkAccSrc(lastAccSrc, cpuCtrlPkg::accMemory);
        end
    endtask

    task automatic testStore();
        runInstruction(cpuCtrlPkg::opStore, 2'd1, 1'b0);
        checkCount_("store writes", writes, 1);
        checkCount_("store accLoads", accLoads, 0);
        checkCount_("store pcLoads", pcLoads, 0);
    endtask

    task automatic testBranchJump();
        runInstruction(cpuCtrlPkg::opBranch, 2'd0, 1'b0);
        checkCount_("branch not taken pcLoads", pcLoads, 0);
        runInstruction(cpuCtrlPkg::opBranch, 2'd0, 1'b1);
        checkCount_("branch imm pcLoads", pcLoads, 1);
        checkPcSrc(lastPcSrc, cpuCtrlPkg::pcFromOperand);
        runInstruction(cpuCtrlPkg::opBranch, 2'd3, 1'b1);
        checkCount_("branch mem reads before pcLoad", readsAtPcLoad, 1);
        checkPcSrc(lastPcSrc, cpuCtrlPkg::pcFromMemory);
        runInstruction(cpuCtrlPkg::opJump, 2'd0, 1'b0);
        checkCount_("jump imm pcLoads", pcLoads, 1);
        checkPcSrc(lastPcSrc, cpuCtrlPkg::pcFromOperand);
        runInstruction(cpuCtrlPkg::opJump, 2'd2, 1'b0);
        checkCount_("jump mem reads before pcLoad", readsAtPcLoad, 1);
        checkPcSrc(lastPcSrc, cpuCtrlPkg::pcFromMemory);
    endtask

    task automatic testCallReturn();
        runInstruction(cpuCtrlPkg::opCall, 2'd0, 1'b0);
        checkCount_("call writes", writes, `CTRL_CALL_WORDS);
        checkCount_("call pushes", pushes, `CTRL_CALL_WORDS);
        checkCount_("call pcLoads", pcLoads, 1);
        checkPcSrc(lastPcSrc, cpuCtrlPkg::pcFromOperand);
        runInstruction(cpuCtrlPkg::opReturn, 2'd0, 1'b0);
        checkCount_("return reads", reads, `CTRL_CALL_WORDS);
        checkCount_("return pops", pops, `CTRL_CALL_WORDS);
        checkCount_("return pcLoads", pcLoads, 1);
        checkPcSrc(lastPcSrc, cpuCtrlPkg::pcFromMemory);
        runInstruction(cpuCtrlPkg::opReserved2, 2'd1, 1'b0);
        checkCount_("reserved loads", accLoads + pcLoads + reads + writes, 0);
    endtask

    initial begin
        testResetFetch();
        testImmediate();
        testMemoryOperand();
        testStore();
        testBranchJump();
        testCallReturn();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
rtl/cpuCtrlPkg.sv
rtl/stateSequencer.sv
rtl/datapathControl.sv
rtl/busControl.sv
rtl/cpuController.sv
bench/cpuControllerTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator

verilator --binary --timing -f vlog.f --top-module cpuControllerTb \
    -o cpuControllerTb > build.log 2>&1 \
    && ./obj_dir/cpuControllerTb > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log \
    && { echo "Simulation failed, see sim.log"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
